// File: verification/debug_cases.txt
# command address byteSelect data expected, all hex
# command 0 read, 1 write, 2 run for data cycles, 3 random register write and readback,
# 4 read with run high, 5 write with run high
0 0000 f 00000000 00000000
0 4004 f 00000000 00000000
0 407c f 00000000 00000000
0 8d00 f 00000000 00000000
0 ac00 f 00000000 00000000
0 c000 f 00000000 ffffffff
0 0004 f 00000000 ffffffff
0 8004 f 00000000 ffffffff
3 4004 f 00000000 00000000
3 4040 f 00000000 00000000
3 407c f 00000000 00000000
3 4020 5 00000000 00000000
1 4000 f deadbeef 00000000
0 4000 f 00000000 00000000
1 4008 f 12345678 00000000
0 4008 1 00000000 00000078
0 4008 6 00000000 00345600
0 4008 8 00000000 12000000
1 8d00 f a5a5c3c3 00000000
0 8d00 f 00000000 a5a5c3c3
0 8d00 c 00000000 a5a50000
1 0000 f 80001235 00000000
0 0000 f 00000000 80001234
0 0000 3 00000000 00001234
0 bc44 f 00000000 00025280
0 bc44 2 00000000 00005200
0 bc4c f 00000000 0000c0de
0 bc50 f 00000000 00000003
2 0000 f 00000007 00000000
0 ac00 f 00000000 00000007
0 ae00 f 00000000 00000000
5 4008 f ffffffff 00000000
0 4008 f 00000000 12345678
5 0000 f 00000100 00000000
0 0000 f 00000000 80001234
4 4008 f 00000000 ffffffff
4 8d00 3 00000000 0000ffff
0 ac00 f 00000000 0000000b
2 0000 f 00000019 00000000
0 ac00 f 00000000 00000024

// File: tb.f
+incdir+source
source/debugAddressPkg.sv
source/coreDataPkg.sv
source/managementDecode.sv
source/registerBank.sv
source/systemRegisters.sv
source/debugReadback.sv
source/coreDebugTop.sv
verification/coreDebugTb.sv

// File: Makefile
TOP = coreDebugTb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "Simulation did not report a pass"; exit 1)

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/coreDebugTb.sv
`timescale 1ns/1ps

module coreDebugTb;

	import coreDataPkg::*;
	import debugAddressPkg::*;

	localparam int CLOCK_PERIOD = 10;
	localparam int RESET_CYCLES = 10;
	localparam string CASE_FILE = "verification/debug_cases.txt";

	// One line of the case file
	typedef struct packed {
		logic [3:0] command;
		mgmtAddr_t address;
		byteSelect_t byteSelect;
		word_t data;
		word_t expected;
	} testCase_t;

	logic clk = 1'b0;
	logic rst;
	mgmtRequest_t request;
	logic run;
	logic [7:0] coreIndex;
	logic [10:0] manufacturerID;
	logic [15:0] partID;
	mgmtResponse_t response;

	testCase_t cases[$];
	logic [31:0] lcgState = 32'h270ce4bf;

	coreDebugTop u_dut (
		.clk(clk),
		.rst(rst),
		.request(request),
		.run(run),
		.coreIndex(coreIndex),
		.manufacturerID(manufacturerID),
		.partID(partID),
		.response(response)
	);

	always #(CLOCK_PERIOD / 2) clk = ~clk;

	function automatic word_t nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Full byte for every selected lane
	function automatic word_t laneMask(input byteSelect_t byteSelect);
		word_t mask;
		for (int lane = 0; lane < 4; lane++) begin
			mask[lane*8 +: 8] = {8{byteSelect[lane]}};
		end
		return mask;
	endfunction

	task automatic failRun();
		$display("ERRORS FOUND");
		$fatal(1, "Stopped at the first failing check");
	endtask

	task automatic compareWord(input word_t actual, input word_t expected, input string what);
		if (actual !== expected) begin
			$display("ERR %0t %s: got %h, expected %h", $time, what, actual, expected);
			failRun();
		end
	endtask

	task automatic compareValid(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("ERR %0t %s: got %b, expected %b", $time, what, actual, expected);
			failRun();
		end
	endtask

	task automatic loadCases();
		int fd;
		int fields;
		string line;
		int unsigned command;
		int unsigned address;
		int unsigned byteSelect;
		word_t data;
		word_t expected;
		testCase_t entry;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the case file %s", CASE_FILE);
			failRun();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Comment and blank lines do not parse
				fields = $sscanf(line, "%h %h %h %h %h",
					command, address, byteSelect, data, expected);
				if (fields == 5) begin
					entry.command = command[3:0];
					entry.address = address[15:0];
					entry.byteSelect = byteSelect[3:0];
					entry.data = data;
					entry.expected = expected;
					cases.push_back(entry);
				end
			end
			$fclose(fd);
		end
	endtask

	// Drives one strobe and checks the response a cycle later
	task automatic accessDut(input logic write, input mgmtAddr_t address,
		input byteSelect_t byteSelect, input word_t data, input logic runLevel,
		input word_t expected);
		@(posedge clk);
		#1;
		request.valid = 1'b1;
		request.write = write;
		request.byteSelect = byteSelect;
		request.address = address;
		request.writeData = data;
		run = runLevel;
		@(posedge clk);
		#1;
		request = '0;
		run = 1'b0;
		compareValid(response.valid, !write, $sformatf("response valid at %h", address));
		if (!write) begin
			compareWord(response.readData, expected, $sformatf("read data at %h", address));
		end
		if (runLevel) begin
			// Let the run state fall back to halted
			repeat (2) @(posedge clk);
			#1;
		end
	endtask

	task automatic holdRun(input int cycles);
		@(posedge clk);
		#1;
		run = 1'b1;
		repeat (cycles) @(posedge clk);
		#1;
		run = 1'b0;
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic runCase(input testCase_t entry);
		word_t randomWord;
		case (entry.command)
			4'd0: accessDut(1'b0, entry.address, entry.byteSelect, entry.data, 1'b0,
				entry.expected);
			4'd1: accessDut(1'b1, entry.address, entry.byteSelect, entry.data, 1'b0, '0);
			4'd2: holdRun(int'(entry.data));
			4'd3: begin
				randomWord = nextRandom();
				accessDut(1'b1, entry.address, 4'hF, randomWord, 1'b0, '0);
				accessDut(1'b0, entry.address, entry.byteSelect, '0, 1'b0,
					randomWord & laneMask(entry.byteSelect));
			end
			4'd4: accessDut(1'b0, entry.address, entry.byteSelect, entry.data, 1'b1,
				entry.expected);
			4'd5: accessDut(1'b1, entry.address, entry.byteSelect, entry.data, 1'b1, '0);
			default: begin
				$display("Unknown command %0h in the case file", entry.command);
				failRun();
			end
		endcase
	endtask

	initial begin
		int runCycles;
		int watchdogCycles;
		rst = 1'b1;
		request = '0;
		// Read strobe held through reset
		request.valid = 1'b1;
		run = 1'b0;
		coreIndex = 8'h03;
		manufacturerID = 11'h4A5;
		partID = 16'hC0DE;
		runCycles = 0;
		loadCases();
		foreach (cases[i]) begin
			if (cases[i].command == 4'd2) begin
				runCycles += int'(cases[i].data);
			end
		end
		watchdogCycles = (cases.size() + runCycles) * 20;
		fork
			begin
				#(watchdogCycles * CLOCK_PERIOD);
				$display("Timeout: the cases did not finish within %0d cycles", watchdogCycles);
				failRun();
			end
		join_none
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		request = '0;
		compareValid(response.valid, 1'b0, "response valid after reset");
		foreach (cases[i]) begin
			runCase(cases[i]);
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: source/coreDebugTop.sv
`timescale 1ns/1ps

module coreDebugTop (
	input logic clk,
	input logic rst,
	input coreDataPkg::mgmtRequest_t request,
	input logic run,
	input logic [7:0] coreIndex,
	input logic [10:0] manufacturerID,
	input logic [15:0] partID,
	output coreDataPkg::mgmtResponse_t response
);

	import coreDataPkg::*;
	import debugAddressPkg::*;

	accessSelect_t access;
	word_t regReadData;
	word_t sysReadData;
	logic csrKnown;

	managementDecode u_managementDecode (
		.request(request),
		.run(run),
		.access(access)
	);

	registerBank u_registerBank (
		.clk(clk),
		.rst(rst),
		.access(access),
		.writeData(request.writeData),
		.regReadData(regReadData)
	);

	systemRegisters u_systemRegisters (
		.clk(clk),
		.rst(rst),
		.access(access),
		.writeData(request.writeData),
		.run(run),
		.coreIndex(coreIndex),
		.manufacturerID(manufacturerID),
		.partID(partID),
		.sysReadData(sysReadData),
		.csrKnown(csrKnown)
	);

	debugReadback u_debugReadback (
		.clk(clk),
		.rst(rst),
		.access(access),
		.regReadData(regReadData),
		.sysReadData(sysReadData),
		.csrKnown(csrKnown),
		.response(response)
	);

endmodule

// File: source/debugReadback.sv
`timescale 1ns/1ps

`include "coreDebug_params.svh"

module debugReadback (
	input logic clk,
	input logic rst,
	input debugAddressPkg::accessSelect_t access,
	input coreDataPkg::word_t regReadData,
	input coreDataPkg::word_t sysReadData,
	input logic csrKnown,
	output coreDataPkg::mgmtResponse_t response
);

	import coreDataPkg::*;

	word_t sourceWord;
	word_t maskedWord;

	// Misses and reads while running return all ones
	always_comb begin
		if (access.selectPc) begin
			sourceWord = sysReadData;
		end else if (access.selectRegister) begin
			sourceWord = regReadData;
		end else if (access.selectCsr && csrKnown) begin
			sourceWord = sysReadData;
		end else begin
			sourceWord = '1;
		end
	end

	always_comb begin
		for (int lane = 0; lane < `BYTE_LANES; lane++) begin
			maskedWord[lane*8 +: 8] = access.byteSelect[lane] ? sourceWord[lane*8 +: 8] : 8'h00;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			response.valid <= 1'b0;
		end else begin
			response.valid <= access.readValid;
		end
		response.readData <= maskedWord;
	end

	responseFollowsRead: assert property (
		@(posedge clk) disable iff (rst)
		response.valid |-> $past(access.readValid)
	) else $error("debugReadback: response without a read on the cycle before");

endmodule

// File: source/systemRegisters.sv
`timescale 1ns/1ps

`include "coreDebug_params.svh"

module systemRegisters (
	input logic clk,
	input logic rst,
	input debugAddressPkg::accessSelect_t access,
	input coreDataPkg::word_t writeData,
	input logic run,
	input logic [7:0] coreIndex,
	input logic [10:0] manufacturerID,
	input logic [15:0] partID,
	output coreDataPkg::word_t sysReadData,
	output logic csrKnown
);

	import coreDataPkg::*;

	runState_t state;
	word_t programCounter;
	word_t mscratch;
	logic [63:0] cycleCount;
	word_t csrData;
	word_t vendorId;
	word_t implementationId;
	word_t hartId;

	// Run state follows run with one cycle of delay
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= HALTED;
		end else begin
			case (state)
				HALTED: begin
					if (run) state <= EXECUTING;
				end
				EXECUTING: begin
					if (!run) state <= HALTED;
				end
				default: state <= HALTED;
			endcase
		end
	end

	// Counts every cycle spent executing
	always_ff @(posedge clk) begin
		if (rst) begin
			cycleCount <= '0;
		end else if (state == EXECUTING) begin
			cycleCount <= cycleCount + 64'd1;
		end
	end

	// Instructions are halfword aligned at least, so bit 0 is dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			programCounter <= '0;
			mscratch <= '0;
		end else begin
			if (access.selectPc && access.write) begin
				programCounter <= {writeData[31:1], 1'b0};
			end
			if (access.selectCsr && access.write && (access.csrIndex == `CSR_MSCRATCH)) begin
				mscratch <= writeData;
			end
		end
	end

	// JEDEC bank and ID sit in bits 17:7 of mvendorid
	assign vendorId = {14'b0, manufacturerID, 7'b0};
	assign implementationId = {16'b0, partID};
	assign hartId = {24'b0, coreIndex};

	always_comb begin
		csrData = '1;
		csrKnown = 1'b1;
		case (access.csrIndex)
			`CSR_MSCRATCH: csrData = mscratch;
			`CSR_MCYCLE: csrData = cycleCount[31:0];
			`CSR_MCYCLEH: csrData = cycleCount[63:32];
			`CSR_MVENDORID: csrData = vendorId;
			`CSR_MIMPID: csrData = implementationId;
			`CSR_MHARTID: csrData = hartId;
			default: csrKnown = 1'b0;
		endcase
	end

	assign sysReadData = access.selectPc ? programCounter : csrData;

	pcStableWhileExecuting: assert property (
		@(posedge clk) disable iff (rst)
		(state == EXECUTING) |-> $stable(programCounter)
	) else $error("systemRegisters: PC changed while executing");

endmodule

// File: source/registerBank.sv
`timescale 1ns/1ps

`include "coreDebug_params.svh"

module registerBank (
	input logic clk,
	input logic rst,
	input debugAddressPkg::accessSelect_t access,
	input coreDataPkg::word_t writeData,
	output coreDataPkg::word_t regReadData
);

	import coreDataPkg::*;

	word_t registers [`REG_COUNT];
	logic writeEnable;

	// x0 is never written, so its storage stays cleared
	assign writeEnable = access.selectRegister && access.write
		&& (access.regIndex != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				registers[i] <= '0;
			end
		end else begin
			if (writeEnable) begin
				registers[access.regIndex] <= writeData;
			end
		end
	end

	// x0 reads as zero
	always_comb begin
		if (access.regIndex == '0) begin
			regReadData = '0;
		end else begin
			regReadData = registers[access.regIndex];
		end
	end

	registerZeroStable: assert property (
		@(posedge clk) disable iff (rst)
		registers[0] == '0
	) else $error("registerBank: x0 storage holds a nonzero value");

endmodule

// File: source/managementDecode.sv
`timescale 1ns/1ps

`include "coreDebug_params.svh"

module managementDecode (
	input coreDataPkg::mgmtRequest_t request,
	input logic run,
	output debugAddressPkg::accessSelect_t access
);

	import debugAddressPkg::*;

	mgmtAddr_t address;
	logic [1:0] region;
	logic strobe;
	logic pcHit;
	logic registerHit;
	logic csrHit;

	assign address = request.address;
	assign region = address[15:14];

	// Accesses only reach the core while it is halted
	assign strobe = request.valid && !run;

	// PC set lives at offset 0 of the system region
	assign pcHit = (region == `REGION_SYSTEM) && (address[13:4] == 10'h000)
		&& (address[3:0] == `PC_OFFSET_SET);

	// 32 words, upper sub-address bits must be zero
	assign registerHit = (region == `REGION_REGISTERS) && (address[13:7] == 7'h00);

	assign csrHit = (region == `REGION_CSR);

	assign access.selectPc = strobe && pcHit;
	assign access.selectRegister = strobe && registerHit;
	assign access.selectCsr = strobe && csrHit;
	assign access.write = strobe && request.write;

	// Every read strobe gets a response, even with run high or a miss
	assign access.readValid = request.valid && !request.write;

	assign access.regIndex = address[6:2];
	assign access.csrIndex = address[13:2];
	assign access.byteSelect = request.byteSelect;

	always_comb begin
		assert ($onehot0({access.selectPc, access.selectRegister, access.selectCsr}))
			else $error("managementDecode: more than one target selected");
	end

endmodule

// File: source/coreDataPkg.sv
package coreDataPkg;

	`include "coreDebug_params.svh"

	typedef logic [`DATA_WIDTH-1:0] word_t;

	// One bit per byte lane, bit 0 is the low byte
	typedef logic [`BYTE_LANES-1:0] byteSelect_t;

	// Host request, valid is a single-cycle strobe
	typedef struct packed {
		logic valid;
		logic write;
		byteSelect_t byteSelect;
		debugAddressPkg::mgmtAddr_t address;
		word_t writeData;
	} mgmtRequest_t;

	// Read response, valid one cycle after a read strobe
	typedef struct packed {
		logic valid;
		word_t readData;
	} mgmtResponse_t;

	typedef enum logic {
		HALTED = 1'b0,
		EXECUTING = 1'b1
	} runState_t;

endpackage

// File: source/debugAddressPkg.sv
package debugAddressPkg;

	`include "coreDebug_params.svh"

	// Raw management address as seen on the port
	typedef logic [`MGMT_ADDR_WIDTH-1:0] mgmtAddr_t;

	// Integer register number, taken from address bits 6:2
	typedef logic [`REG_INDEX_WIDTH-1:0] regIndex_t;

	// CSR number, taken from address bits 13:2
	typedef logic [`CSR_INDEX_WIDTH-1:0] csrIndex_t;

	// Decoded form of one request
	typedef struct packed {
		logic selectPc;
		logic selectRegister;
		logic selectCsr;
		logic write;
		logic readValid;
		regIndex_t regIndex;
		csrIndex_t csrIndex;
		logic [`BYTE_LANES-1:0] byteSelect;
	} accessSelect_t;

endpackage

// File: source/coreDebug_params.svh
`ifndef COREDEBUG_PARAMS_SVH
`define COREDEBUG_PARAMS_SVH

// Core word and register file
`define DATA_WIDTH 32
`define BYTE_LANES 4
`define REG_COUNT 32
`define REG_INDEX_WIDTH 5

// Management address map, region code in bits 15:14
`define MGMT_ADDR_WIDTH 16
`define CSR_INDEX_WIDTH 12
`define REGION_SYSTEM 2'b00
`define REGION_REGISTERS 2'b01
`define REGION_CSR 2'b10
`define PC_OFFSET_SET 4'h0

// Machine CSRs that are kept
`define CSR_MSCRATCH 12'h340
`define CSR_MCYCLE 12'hB00
`define CSR_MCYCLEH 12'hB80
`define CSR_MVENDORID 12'hF11
`define CSR_MIMPID 12'hF13
`define CSR_MHARTID 12'hF14

`endif
